// ==== include/synth_params.svh ====
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// UART oversampling, clocks per serial bit
`define UART_CLKS_PER_BIT 8

// Notes 0..NOTE_COUNT-1 are accepted as note bytes
`define NOTE_COUNT 60
`define RESET_NOTE 33

// Noise generator start value, must be nonzero
`define LFSR_SEED 16'hACE1

// Bits per I2S channel word
`define I2S_WORD_BITS 16

`endif

// ==== verilog/synth_cmd_pkg.sv ====
`default_nettype none

package synth_cmd_pkg;

    // Waveform selected by the command bytes
    typedef enum logic [1:0] {
        WAVE_TRIANGLE = 2'd0,
        WAVE_SAWTOOTH = 2'd1,
        WAVE_SQUARE   = 2'd2
    } wave_t;

    // Note index 0..59, octave = index / 12, semitone = index % 12
    typedef logic [5:0] note_t;

    localparam logic [7:0] CMD_TRIANGLE  = 8'h54;  // 'T'
    localparam logic [7:0] CMD_SAWTOOTH  = 8'h53;  // 'S'
    localparam logic [7:0] CMD_SQUARE    = 8'h51;  // 'Q'
    localparam logic [7:0] CMD_NOISE_ON  = 8'h4E;  // 'N'
    localparam logic [7:0] CMD_NOISE_OFF = 8'h46;  // 'F'

endpackage

`default_nettype wire

// ==== verilog/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    typedef logic [7:0] sample_t;  // Unsigned audio sample

    // Octave the period table is written for
    localparam int PERIOD_OCTAVE = 4;

    // Clock counts per phase step for C..B of PERIOD_OCTAVE
    localparam logic [15:0] SEMITONE_PERIOD [0:11] = '{
        16'd121,  // C
        16'd114,
        16'd108,  // D
        16'd102,
        16'd96,   // E
        16'd91,   // F
        16'd86,
        16'd81,   // G
        16'd76,
        16'd72,   // A
        16'd68,
        16'd64    // B
    };

endpackage

`default_nettype wire

// ==== verilog/uart_byte_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "synth_params.svh"

module uart_byte_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    input  logic       byte_ack,
    output logic [7:0] byte_data,
    output logic       byte_req
);

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
    localparam int TIMER_W      = $clog2(CLKS_PER_BIT);
    localparam logic [TIMER_W-1:0] HALF_BIT = TIMER_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [TIMER_W-1:0] FULL_BIT = TIMER_W'(CLKS_PER_BIT - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP,
        ST_HOLD
    } state_t;

    state_t             state;
    logic [1:0]         rx_sync;
    logic               rx_s;
    logic [TIMER_W-1:0] bit_timer;
    logic [2:0]         bit_cnt;
    logic [7:0]         shift_reg;
    logic               bit_done;

    assign rx_s     = rx_sync[1];
    assign bit_done = (bit_timer == FULL_BIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;  // Line idles high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            bit_timer <= '0;
            bit_cnt   <= '0;
            byte_req  <= 1'b0;
        end else begin
            bit_timer <= bit_timer + 1'b1;
            case (state)
                ST_IDLE: begin
                    bit_timer <= '0;
                    if (!rx_s) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_timer == HALF_BIT) begin
                        bit_timer <= '0;
                        bit_cnt   <= '0;
                        state     <= rx_s ? ST_IDLE : ST_DATA;  // Short glitch is rejected
                    end
                end
                ST_DATA: begin
                    if (bit_done) begin
                        bit_timer <= '0;
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        if (rx_s) begin  // Good stop bit
                            byte_req <= 1'b1;
                            state    <= ST_HOLD;
                        end else begin
                            state <= ST_IDLE;  // Framing error, byte dropped
                        end
                    end
                end
                ST_HOLD: begin
                    if (byte_ack) begin
                        byte_req <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == ST_DATA && bit_done) begin
            shift_reg <= {rx_s, shift_reg[7:1]};
        end
        if (state == ST_STOP && bit_done && rx_s) begin
            byte_data <= shift_reg;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/command_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "synth_params.svh"

module command_decoder import synth_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] byte_data,
    input  logic       byte_req,
    output logic       byte_ack,
    output wave_t      wave_sel,
    output note_t      note,
    output logic       noise_en
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_ack <= 1'b0;
            wave_sel <= WAVE_TRIANGLE;
            note     <= note_t'(`RESET_NOTE);
            noise_en <= 1'b0;
        end else if (byte_req && !byte_ack) begin
            byte_ack <= 1'b1;  // Settings update on the same edge
            case (byte_data)
                CMD_TRIANGLE:  wave_sel <= WAVE_TRIANGLE;
                CMD_SAWTOOTH:  wave_sel <= WAVE_SAWTOOTH;
                CMD_SQUARE:    wave_sel <= WAVE_SQUARE;
                CMD_NOISE_ON:  noise_en <= 1'b1;
                CMD_NOISE_OFF: noise_en <= 1'b0;
                default: begin
                    if (byte_data < 8'(`NOTE_COUNT)) begin
                        note     <= note_t'(byte_data);
                        wave_sel <= WAVE_SAWTOOTH;  // Note byte implies sawtooth
                        noise_en <= 1'b0;
                    end
                    // Anything else is acknowledged and dropped
                end
            endcase
        end else if (!byte_req) begin
            byte_ack <= 1'b0;  // Close the four-phase cycle
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pitch_divider.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "synth_params.svh"

module pitch_divider import synth_cmd_pkg::*, audio_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  note_t note,
    output logic  phase_step
);

    logic [2:0]  octave;
    logic [3:0]  semitone;
    logic [2:0]  shift;
    logic [15:0] period;
    logic [15:0] count;
    note_t       prev_note;

    assign octave   = 3'(note / 6'd12);
    assign semitone = 4'(note % 6'd12);
    assign shift    = 3'(PERIOD_OCTAVE) - octave;  // Lower octaves get longer periods
    assign period   = SEMITONE_PERIOD[semitone] << shift;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count      <= '0;
            phase_step <= 1'b0;
            prev_note  <= note_t'(`RESET_NOTE);
        end else begin
            prev_note <= note;
            if (note != prev_note) begin
                count      <= '0;  // New note restarts the period
                phase_step <= 1'b0;
            end else if (count == period - 16'd1) begin
                count      <= '0;
                phase_step <= 1'b1;
            end else begin
                count      <= count + 16'd1;
                phase_step <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wave_generator.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "synth_params.svh"

module wave_generator import synth_cmd_pkg::*, audio_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    phase_step,
    input  wave_t   wave_sel,
    input  logic    noise_en,
    input  logic    sample_req,
    output sample_t sample,
    output logic    sample_ack
);

    sample_t     saw_cnt;
    sample_t     tri_cnt;
    logic        tri_up;
    sample_t     tri_next;
    logic        sq_state;
    logic [15:0] lfsr;
    logic        lfsr_fb;
    sample_t     next_sample;

    assign tri_next = tri_up ? tri_cnt + 8'd1 : tri_cnt - 8'd1;
    assign lfsr_fb  = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // Taps 16, 14, 13, 11

    // Phase state, moves only on a step pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saw_cnt  <= '0;
            tri_cnt  <= '0;
            tri_up   <= 1'b1;
            sq_state <= 1'b0;
            lfsr     <= `LFSR_SEED;
        end else if (phase_step) begin
            saw_cnt  <= saw_cnt + 8'd1;  // Wraps 0xFF to 0x00
            tri_cnt  <= tri_next;
            sq_state <= ~sq_state;
            lfsr     <= {lfsr[14:0], lfsr_fb};
            if (tri_next == 8'hFF) begin
                tri_up <= 1'b0;
            end else if (tri_next == 8'h00) begin
                tri_up <= 1'b1;
            end
        end
    end

    always_comb begin
        if (noise_en) begin
            next_sample = lfsr[15:8];
        end else begin
            case (wave_sel)
                WAVE_TRIANGLE: next_sample = tri_cnt;
                WAVE_SAWTOOTH: next_sample = saw_cnt;
                WAVE_SQUARE:   next_sample = sq_state ? 8'hFF : 8'h00;
                default:       next_sample = '0;
            endcase
        end
    end

    // Sample handshake toward the I2S side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample     <= '0;
            sample_ack <= 1'b0;
        end else if (sample_req && !sample_ack) begin
            sample     <= next_sample;
            sample_ack <= 1'b1;
        end else if (!sample_req) begin
            sample_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/i2s_transmitter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "synth_params.svh"

module i2s_transmitter import audio_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample,
    input  logic    sample_ack,
    output logic    sample_req,
    output logic    i2s_sck,
    output logic    i2s_ws,
    output logic    i2s_sd
);

    localparam int WORD_BITS  = `I2S_WORD_BITS;
    localparam int FRAME_BITS = 2 * WORD_BITS;
    localparam int REPEAT     = FRAME_BITS / $bits(sample_t);  // Sample copies per frame
    localparam int CNT_W      = $clog2(FRAME_BITS);

    logic [CNT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shift_reg;
    logic [FRAME_BITS-1:0] frame_word;
    logic                  frame_start;
    sample_t               next_sample;

    assign frame_start = (bit_cnt == '0);
    assign frame_word  = frame_start ? {REPEAT{next_sample}} : shift_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            i2s_sck     <= 1'b0;
            i2s_ws      <= 1'b0;
            i2s_sd      <= 1'b0;
            bit_cnt     <= '0;
            sample_req  <= 1'b0;
            next_sample <= '0;
        end else begin
            i2s_sck <= ~i2s_sck;
            if (i2s_sck) begin  // Falling edge of the bit clock
                i2s_sd  <= frame_word[FRAME_BITS-1];  // MSB first
                i2s_ws  <= (bit_cnt >= CNT_W'(WORD_BITS));
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (i2s_sck && frame_start) begin
                sample_req <= 1'b1;  // Fetch the sample for the next frame
            end else if (sample_req && sample_ack) begin
                next_sample <= sample;
                sample_req  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i2s_sck) begin
            shift_reg <= {frame_word[FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tone_synth.sv ====
`timescale 1ns/100ps
`default_nettype none

module tone_synth import synth_cmd_pkg::*, audio_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rx,
    output logic i2s_sck,
    output logic i2s_ws,
    output logic i2s_sd
);

    logic [7:0] byte_data;
    logic       byte_req;
    logic       byte_ack;
    wave_t      wave_sel;
    note_t      note;
    logic       noise_en;
    logic       phase_step;
    sample_t    sample;
    logic       sample_req;
    logic       sample_ack;

    uart_byte_rx i_uart_byte_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (uart_rx),
        .byte_ack  (byte_ack),
        .byte_data (byte_data),
        .byte_req  (byte_req)
    );

    command_decoder i_command_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_data (byte_data),
        .byte_req  (byte_req),
        .byte_ack  (byte_ack),
        .wave_sel  (wave_sel),
        .note      (note),
        .noise_en  (noise_en)
    );

    pitch_divider i_pitch_divider (
        .clk        (clk),
        .rst_n      (rst_n),
        .note       (note),
        .phase_step (phase_step)
    );

    wave_generator i_wave_generator (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase_step (phase_step),
        .wave_sel   (wave_sel),
        .noise_en   (noise_en),
        .sample_req (sample_req),
        .sample     (sample),
        .sample_ack (sample_ack)
    );

    i2s_transmitter i_i2s_transmitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample     (sample),
        .sample_ack (sample_ack),
        .sample_req (sample_req),
        .i2s_sck    (i2s_sck),
        .i2s_ws     (i2s_ws),
        .i2s_sd     (i2s_sd)
    );

endmodule

`default_nettype wire

// ==== test/tb_i2s_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "synth_params.svh"

module tb_i2s_checker import synth_cmd_pkg::*, audio_pkg::*; (
    input  logic  i2s_sck,
    input  logic  i2s_ws,
    input  logic  i2s_sd,
    input  logic  check_en,
    input  wave_t wave_rule,
    input  logic  noise_rule,
    input  int    run_min,
    input  int    run_max,
    output int    frame_count,
    output logic  noise_locked,
    output logic  failed
);

    localparam int WORD_BITS  = `I2S_WORD_BITS;
    localparam int FRAME_BITS = 2 * WORD_BITS;
    localparam int HIST_LEN   = 10;  // Distinct noise samples used to find the LFSR state

    logic                  synced = 1'b0;
    logic                  prev_ws = 1'b0;
    int                    bit_idx = 0;
    logic [FRAME_BITS-1:0] word;
    sample_t               prev;
    logic                  have_prev = 1'b0;
    int                    last_dir;
    int                    run_len;
    int                    runs_seen;
    sample_t               noise_hist [HIST_LEN];
    int                    hist_cnt;
    logic                  locked;
    logic [15:0]           model;

    assign noise_locked = locked;

    initial begin
        frame_count = 0;
        failed      = 1'b0;
    end

    task automatic report(input string msg);
        $display("%s", msg);
        failed = 1'b1;
    endtask

    // Fibonacci LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Steps that keep the upper byte are invisible in the output
    function automatic logic [15:0] next_visible(input logic [15:0] s, input sample_t shown);
        logic [15:0] t;
        int          guard;
        t     = lfsr_next(s);
        guard = 0;
        while (t[15:8] == shown && guard < 16) begin
            t     = lfsr_next(t);
            guard = guard + 1;
        end
        return t;
    endfunction

    // Walk the sequence from the seed until it matches the collected history
    task automatic lock_lfsr();
        logic [15:0] state;
        logic [15:0] t;
        logic        ok;
        int          k;
        int          j;
        state  = `LFSR_SEED;
        locked = 1'b0;
        for (k = 0; k < 65536 && !locked; k++) begin
            if (state[15:8] == noise_hist[0]) begin
                t  = state;
                ok = 1'b1;
                for (j = 1; j < HIST_LEN && ok; j++) begin
                    t  = next_visible(t, noise_hist[j-1]);
                    ok = (t[15:8] == noise_hist[j]);
                end
                if (ok) begin
                    model  = t;
                    locked = 1'b1;
                end
            end
            state = lfsr_next(state);
        end
        assert (locked) else report("Noise samples do not follow the LFSR sequence from the seed");
    endtask

    task automatic check_triangle(input sample_t s);
        int dir;
        if (s != prev) begin
            dir = 0;
            if (prev != 8'hFF && s == 8'(prev + 8'd1)) begin
                dir = 1;
            end else if (prev != 8'h00 && s == 8'(prev - 8'd1)) begin
                dir = -1;
            end
            assert (dir != 0) else report($sformatf(
                "MISMATCH sample: got 0x%02h expected 0x%02h plus or minus one", s, prev));
            if (dir != 0 && last_dir != 0 && dir != last_dir) begin
                assert (prev == 8'h00 || prev == 8'hFF) else report($sformatf(
                    "MISMATCH triangle turn: got 0x%02h expected 0x00 or 0xff", prev));
            end
            last_dir = dir;
        end
    endtask

    task automatic check_square(input sample_t s);
        assert (s == 8'h00 || s == 8'hFF) else report($sformatf(
            "MISMATCH sample: got 0x%02h expected 0x00 or 0xff", s));
        if (s == prev) begin
            run_len = run_len + 1;
            // Even the partial first run cannot outlast one step
            assert (run_len <= run_max) else report($sformatf(
                "MISMATCH square run length: got 0x%0h expected at most 0x%0h",
                run_len, run_max));
        end else begin
            if (runs_seen > 0) begin  // First run is partial
                assert (run_len >= run_min && run_len <= run_max) else report($sformatf(
                    "MISMATCH square run length: got 0x%0h expected 0x%0h to 0x%0h",
                    run_len, run_min, run_max));
            end
            runs_seen = runs_seen + 1;
            run_len   = 1;
        end
    endtask

    task automatic check_noise(input sample_t s);
        logic [15:0] expected;
        if (s != prev) begin
            if (!locked && hist_cnt < HIST_LEN) begin
                noise_hist[hist_cnt] = s;
                hist_cnt             = hist_cnt + 1;
                if (hist_cnt == HIST_LEN) begin
                    lock_lfsr();
                end
            end else if (locked) begin
                expected = next_visible(model, prev);
                assert (s == expected[15:8]) else report($sformatf(
                    "MISMATCH noise sample: got 0x%02h expected 0x%02h", s, expected[15:8]));
                model = expected;
            end
        end
    endtask

    task automatic check_sample(input sample_t s);
        if (!check_en) begin
            have_prev = 1'b0;
        end else if (!have_prev) begin  // Baseline after a rule change
            have_prev     = 1'b1;
            prev          = s;
            last_dir      = 0;
            run_len       = 1;
            runs_seen     = 0;
            noise_hist[0] = s;
            hist_cnt      = 1;
            locked        = 1'b0;
        end else begin
            if (noise_rule) begin
                check_noise(s);
            end else begin
                case (wave_rule)
                    WAVE_TRIANGLE: check_triangle(s);
                    WAVE_SAWTOOTH: begin
                        assert (s == prev || s == 8'(prev + 8'd1)) else report($sformatf(
                            "MISMATCH sample: got 0x%02h expected 0x%02h or 0x%02h",
                            s, prev, 8'(prev + 8'd1)));
                    end
                    WAVE_SQUARE:   check_square(s);
                    default:       report("Checker has no rule for the selected waveform");
                endcase
            end
            prev = s;
        end
    endtask

    task automatic check_frame(input logic [FRAME_BITS-1:0] w);
        int i;
        for (i = 0; i < 3; i++) begin  // All four bytes carry the sample
            assert (w[8*i +: 8] == w[31:24]) else report($sformatf(
                "MISMATCH i2s_sd byte %0d: got 0x%02h expected 0x%02h", i, w[8*i +: 8], w[31:24]));
        end
        check_sample(w[31:24]);
    endtask

    always @(posedge i2s_sck) begin
        if (!synced && prev_ws && !i2s_ws) begin  // Frame starts where ws falls
            synced  = 1'b1;
            bit_idx = 0;
        end
        if (synced) begin
            assert (i2s_ws == (bit_idx >= WORD_BITS)) else report($sformatf(
                "MISMATCH i2s_ws: got 0x%0h expected 0x%0h at bit %0d",
                i2s_ws, bit_idx >= WORD_BITS, bit_idx));
            word    = {word[FRAME_BITS-2:0], i2s_sd};
            bit_idx = bit_idx + 1;
            if (bit_idx == FRAME_BITS) begin
                bit_idx = 0;
                check_frame(word);
                frame_count = frame_count + 1;
            end
        end
        prev_ws = i2s_ws;
    end

endmodule

`default_nettype wire

// ==== test/tb_tone_synth.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "synth_params.svh"

module tb_tone_synth import synth_cmd_pkg::*, audio_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int FRAME_CLKS    = 4 * `I2S_WORD_BITS;
    localparam int SETTLE_FRAMES = 4;
    localparam int TRI_FRAMES    = 1300;  // Long enough to turn at 0xff
    localparam int SAW_FRAMES    = 200;
    localparam int SQ_FRAMES     = 200;
    localparam int SAW2_FRAMES   = 60;
    localparam int SQ2_FRAMES    = 120;
    localparam int IGNORE_FRAMES = 150;
    localparam int NOISE_FRAMES  = 500;
    localparam int OFF_FRAMES    = 100;
    localparam int BYTE_CLKS     = 12 * `UART_CLKS_PER_BIT + 64;
    localparam int TOTAL_FRAMES  = TRI_FRAMES + SAW_FRAMES + SQ_FRAMES + SAW2_FRAMES
                                 + SQ2_FRAMES + IGNORE_FRAMES + NOISE_FRAMES + OFF_FRAMES
                                 + 6 * SETTLE_FRAMES;
    localparam longint RUN_CLKS  = longint'(TOTAL_FRAMES + 300) * FRAME_CLKS
                                 + 10 * BYTE_CLKS;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  uart_rx;
    logic  i2s_sck;
    logic  i2s_ws;
    logic  i2s_sd;
    logic  check_en;
    wave_t wave_rule;
    logic  noise_rule;
    int    run_min;
    int    run_max;
    int    frame_count;
    logic  noise_locked;
    logic  check_failed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    tone_synth i_tone_synth (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_rx (uart_rx),
        .i2s_sck (i2s_sck),
        .i2s_ws  (i2s_ws),
        .i2s_sd  (i2s_sd)
    );

    tb_i2s_checker i_i2s_checker (
        .i2s_sck      (i2s_sck),
        .i2s_ws       (i2s_ws),
        .i2s_sd       (i2s_sd),
        .check_en     (check_en),
        .wave_rule    (wave_rule),
        .noise_rule   (noise_rule),
        .run_min      (run_min),
        .run_max      (run_max),
        .frame_count  (frame_count),
        .noise_locked (noise_locked),
        .failed       (check_failed)
    );

    task automatic uart_bit(input logic v);
        @(posedge clk);
        #2 uart_rx = v;
        repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    // 8N1, LSB first; a low stop bit makes a framing error
    task automatic send_byte(input logic [7:0] b, input logic stop_ok);
        int gap;
        int i;
        uart_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            uart_bit(b[i]);
        end
        uart_bit(stop_ok);
        @(posedge clk);
        #2 uart_rx = 1'b1;
        gap = $urandom_range(24, 4) + (stop_ok ? 0 : 40);
        repeat (gap) @(posedge clk);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target) begin
            @(posedge clk);
        end
    endtask

    // Pause checking while the command takes effect
    task automatic apply_rule(input logic [7:0] cmd, input wave_t w, input logic noise,
                              input int rmin, input int rmax);
        @(posedge clk);
        #2 check_en = 1'b0;
        send_byte(cmd, 1'b1);
        wait_frames(SETTLE_FRAMES);
        @(posedge clk);
        #2;
        wave_rule  = w;
        noise_rule = noise;
        run_min    = rmin;
        run_max    = rmax;
        check_en   = 1'b1;
    endtask

    always @(posedge check_failed) begin
        $display("TEST RESULT: FAIL");
        $fatal(1, "Checker reported an error");
    end

    initial begin
        #(RUN_CLKS * CLK_PERIOD);
        $display("Timeout, the scenarios did not finish in time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        void'($urandom(32'hb8fb7380));
        rst_n      = 1'b0;
        uart_rx    = 1'b1;
        check_en   = 1'b0;
        wave_rule  = WAVE_TRIANGLE;
        noise_rule = 1'b0;
        run_min    = 0;
        run_max    = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n    = 1'b1;
        check_en = 1'b1;  // Triangle from reset
        wait_frames(TRI_FRAMES);

        apply_rule(8'h00, WAVE_SAWTOOTH, 1'b0, 0, 0);
        wait_frames(SAW_FRAMES);
        apply_rule(CMD_SQUARE, WAVE_SQUARE, 1'b0, 30, 31);  // 1936 clocks per step
        wait_frames(SQ_FRAMES);
        apply_rule(8'h0C, WAVE_SAWTOOTH, 1'b0, 0, 0);
        wait_frames(SAW2_FRAMES);
        apply_rule(CMD_SQUARE, WAVE_SQUARE, 1'b0, 15, 16);  // 968 clocks per step
        wait_frames(SQ2_FRAMES);

        // Checking stays on, nothing may change
        send_byte(8'h57, 1'b1);
        send_byte(8'h3C, 1'b1);
        send_byte(8'h00, 1'b0);
        wait_frames(IGNORE_FRAMES);

        apply_rule(CMD_NOISE_ON, WAVE_SQUARE, 1'b1, 15, 16);
        wait_frames(NOISE_FRAMES);
        assert (noise_locked) else begin
            $display("Noise samples never lined up with the LFSR sequence");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Noise check did not run");
        end
        apply_rule(CMD_NOISE_OFF, WAVE_SQUARE, 1'b0, 15, 16);
        wait_frames(OFF_FRAMES);

        if (check_failed) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Checks failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
verilog/synth_cmd_pkg.sv
verilog/audio_pkg.sv
verilog/uart_byte_rx.sv
verilog/command_decoder.sv
verilog/pitch_divider.sv
verilog/wave_generator.sv
verilog/i2s_transmitter.sv
verilog/tone_synth.sv
test/tb_i2s_checker.sv
test/tb_tone_synth.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tone_synth
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
